//--- build.f
+incdir+testbench
rtl/sparse_buffer_pkg.sv
rtl/sample_fifo.sv
rtl/sample_discriminator.sv
rtl/buffer_config_regs.sv
rtl/buffer_readout.sv
rtl/sparse_sample_buffer.sv
testbench/tb_clock.sv
testbench/sparse_sample_buffer_tb.sv

//--- rtl/buffer_config_regs.sv
/*
 * APB slave for the sparse sample buffer.
 * Holds per-channel thresholds, turns ctrl writes into start and stop
 * pulses, and reports capture, readout and full status. No wait states.
 */
`timescale 1ns/1ns

module buffer_config_regs #(
  parameter int channels = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  output sparse_buffer_pkg::thresholds_t [channels-1:0] thresholds,
  output logic start,
  output logic stop,
  input  logic capturing,
  input  logic readout_busy,
  input  logic [channels-1:0] full_flags
);

  logic access;
  logic wr_access;
  logic ctrl_hit;
  logic status_hit;
  logic thresh_hit;
  logic [11:0] thresh_offset;
  logic [9:0] thresh_idx;

  ////////////////////
  // address decode
  ////////////////////
  always_comb begin
    thresh_offset = paddr - sparse_buffer_pkg::reg_thresh_base;
    thresh_idx = thresh_offset[11:2];
    ctrl_hit = (paddr == sparse_buffer_pkg::reg_ctrl_addr);
    status_hit = (paddr == sparse_buffer_pkg::reg_status_addr);
    thresh_hit = (paddr >= sparse_buffer_pkg::reg_thresh_base)
        && (thresh_offset < 12'(4 * channels))
        && (paddr[1:0] == 2'b00);
  end

  assign access = psel && penable;
  assign wr_access = access && pwrite;
  assign pready = 1'b1;
  assign pslverr = access && !(ctrl_hit || status_hit || thresh_hit);

  // ctrl reads back as zero since its bits are pulses
  always_comb begin
    prdata = '0;
    if (status_hit) begin
      prdata[0] = capturing;
      prdata[1] = readout_busy;
      prdata[8 +: channels] = full_flags;
    end else if (thresh_hit) begin
      prdata = thresholds[thresh_idx];
    end
  end

  ////////////////////
  // register writes
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      thresholds <= '0;
      start <= 1'b0;
      stop <= 1'b0;
    end else begin
      // start wins when both bits are written
      start <= wr_access && ctrl_hit && pwdata[0] && !readout_busy;
      stop <= wr_access && ctrl_hit && pwdata[1] && !pwdata[0] && capturing;
      if (wr_access && thresh_hit) thresholds[thresh_idx] <= pwdata;
    end
  end

  // each ctrl write gives a single one-cycle pulse
  a_ctrl_pulse_single: assert property (@(posedge clk) disable iff (reset)
    (start || stop) |=> !(start || stop));

endmodule

//--- rtl/buffer_readout.sv
/*
 * Drains all channel FIFOs after a stop into one framed word stream.
 * Per channel: timestamp header, timestamps, data header, data.
 * A one-word holding register drives the valid/ready output.
 */
`timescale 1ns/1ns

module buffer_readout #(
  parameter int channels = 4,
  parameter int tstamp_depth = 16,
  parameter int data_depth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic stop,
  input  sparse_buffer_pkg::tstamp_t [channels-1:0] tstamp_data,
  input  logic [channels-1:0][$clog2(tstamp_depth+1)-1:0] tstamp_fill,
  input  logic [channels-1:0] tstamp_empty,
  input  sparse_buffer_pkg::beat_t [channels-1:0] data_data,
  input  logic [channels-1:0][$clog2(data_depth+1)-1:0] data_fill,
  input  logic [channels-1:0] data_empty,
  output logic [channels-1:0] tstamp_rd,
  output logic [channels-1:0] data_rd,
  output logic out_valid,
  output sparse_buffer_pkg::out_word_t out_word,
  input  logic out_ready,
  output logic busy
);

  localparam int ch_width = (channels > 1) ? $clog2(channels) : 1;

  typedef enum logic [2:0] {
    s_idle, s_wait, s_ts_hdr, s_ts, s_data_hdr, s_data
  } state_t;

  state_t state;
  logic [ch_width-1:0] ch;
  logic slot_free;
  logic last_ch;
  logic load;
  sparse_buffer_pkg::out_word_t next_word;
  sparse_buffer_pkg::header_t hdr;

  assign slot_free = !out_valid || out_ready;
  assign last_ch = (ch == ch_width'(channels - 1));
  assign busy = (state != s_idle) || out_valid;

  ////////////////////
  // next output word and FIFO pops
  ////////////////////
  always_comb begin
    load = 1'b0;
    next_word = '0;
    tstamp_rd = '0;
    data_rd = '0;
    hdr = '0;
    hdr.channel = 7'(ch);
    case (state)
      s_ts_hdr: begin
        hdr.count = 24'(tstamp_fill[ch]);
        load = slot_free;
        next_word.data = hdr;
      end
      s_ts: if (!tstamp_empty[ch]) begin
        load = slot_free;
        tstamp_rd[ch] = slot_free;
        next_word.data = tstamp_data[ch];
      end
      s_data_hdr: begin
        hdr.kind = 1'b1;
        hdr.count = 24'(data_fill[ch]);
        load = slot_free;
        next_word.data = hdr;
        // an empty last channel ends on its header
        next_word.last = last_ch && data_empty[ch];
      end
      s_data: if (!data_empty[ch]) begin
        load = slot_free;
        data_rd[ch] = slot_free;
        next_word.data = data_data[ch];
        next_word.last = last_ch && (data_fill[ch] == 1);
      end
      default: ;
    endcase
  end

  ////////////////////
  // channel and phase sequencing
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
      ch <= '0;
    end else begin
      case (state)
        s_idle: if (stop) begin
          state <= s_wait;
          ch <= '0;
        end
        // one cycle for in-flight writes to reach the fill counts
        s_wait: state <= s_ts_hdr;
        s_ts_hdr: if (slot_free) state <= s_ts;
        s_ts: if (tstamp_empty[ch]) state <= s_data_hdr;
        s_data_hdr: if (slot_free) state <= s_data;
        s_data: if (data_empty[ch]) begin
          if (last_ch) begin
            state <= s_idle;
          end else begin
            ch <= ch + 1'b1;
            state <= s_ts_hdr;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) out_valid <= 1'b0;
    else if (load) out_valid <= 1'b1;
    else if (out_ready) out_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (load) out_word <= next_word;
  end

  a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_word));

endmodule

//--- rtl/sample_discriminator.sv
/*
 * Per-channel keep decision with hysteresis.
 * Keeps the beat timer, run state and data index, and issues registered
 * write requests to the channel's data and timestamp FIFOs.
 */
`timescale 1ns/1ns

module sample_discriminator #(
  parameter int tstamp_depth = 16,
  parameter int data_depth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic capturing,
  input  logic in_valid,
  input  sparse_buffer_pkg::beat_t in_beat,
  input  sparse_buffer_pkg::thresholds_t thresholds,
  input  logic [$clog2(data_depth+1)-1:0] data_fill,
  input  logic [$clog2(tstamp_depth+1)-1:0] tstamp_fill,
  output logic data_wr,
  output sparse_buffer_pkg::beat_t data_beat,
  output logic tstamp_wr,
  output sparse_buffer_pkg::tstamp_t tstamp,
  output logic full
);

  localparam int tw = sparse_buffer_pkg::tstamp_field_width;

  logic prev_kept;
  logic [tw-1:0] beat_timer;
  logic [tw-1:0] data_index;
  logic above_high;
  logic above_low;
  logic kept;
  logic run_start;
  logic room;
  logic store;

  always_comb begin
    above_high = 1'b0;
    above_low = 1'b0;
    for (int i = 0; i < sparse_buffer_pkg::parallel_samples; i++) begin
      above_high |= in_beat[i] > thresholds.high;
      above_low |= in_beat[i] > thresholds.low;
    end
    kept = above_high || (prev_kept && above_low);
    run_start = kept && !prev_kept;
    // the fill counts lag by one cycle, so count a write still in flight
    room = (int'(data_fill) + int'(data_wr)) < data_depth
        && (!run_start || (int'(tstamp_fill) + int'(tstamp_wr)) < tstamp_depth);
    store = capturing && in_valid && kept && !full && room;
  end

  always_ff @(posedge clk) begin
    if (reset || start) begin
      prev_kept <= 1'b0;
      beat_timer <= '0;
      data_index <= '0;
      full <= 1'b0;
      data_wr <= 1'b0;
      tstamp_wr <= 1'b0;
    end else begin
      data_wr <= store;
      tstamp_wr <= store && run_start;
      if (capturing && in_valid) begin
        prev_kept <= kept;
        beat_timer <= beat_timer + 1'b1;
        // sticky until the next start
        if (kept && !room) full <= 1'b1;
      end
      if (store) data_index <= data_index + 1'b1;
    end
  end

  // timestamp carries the index before this beat's write
  always_ff @(posedge clk) begin
    data_beat <= in_beat;
    tstamp.beat_timer <= beat_timer;
    tstamp.data_index <= data_index;
  end

  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    data_wr |-> data_fill != data_depth);

endmodule

//--- rtl/sample_fifo.sv
/*
 * Synchronous first-word-fall-through FIFO with a payload type parameter.
 * rd_data shows the oldest entry whenever empty is low, and rd pops it.
 * clear empties the FIFO in one cycle.
 */
`timescale 1ns/1ns

module sample_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int depth = 16
) (
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  logic wr,
  input  payload_t wr_data,
  input  logic rd,
  output payload_t rd_data,
  output logic [$clog2(depth+1)-1:0] fill,
  output logic empty
);

  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

  payload_t mem [depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;

  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
    end else begin
      if (wr) wr_ptr <= next_ptr(wr_ptr);
      if (rd) rd_ptr <= next_ptr(rd_ptr);
      // fill moves only when exactly one side is active
      if (wr && !rd) fill <= fill + 1'b1;
      else if (rd && !wr) fill <= fill - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr) mem[wr_ptr] <= wr_data;
  end

  assign rd_data = mem[rd_ptr];
  assign empty = (fill == '0);

  a_no_read_empty: assert property (@(posedge clk) disable iff (reset) rd |-> !empty);
  a_no_write_full: assert property (@(posedge clk) disable iff (reset)
    wr && !clear |-> fill != depth);

endmodule

//--- rtl/sparse_buffer_pkg.sv
/*
 * Shared types and constants for the sparse sample buffer.
 * Sample and beat widths, timestamp and header layouts, and the APB
 * register map used by the register block and the testbench.
 */

package sparse_buffer_pkg;

  localparam int sample_width = 16;
  localparam int parallel_samples = 2;
  localparam int tstamp_field_width = 16;

  // one beat is a group of samples taken in the same cycle
  typedef logic [parallel_samples-1:0][sample_width-1:0] beat_t;

  typedef struct packed {
    logic [tstamp_field_width-1:0] beat_timer;
    logic [tstamp_field_width-1:0] data_index;
  } tstamp_t;

  // high sits in the upper half of the register word
  typedef struct packed {
    logic [sample_width-1:0] high;
    logic [sample_width-1:0] low;
  } thresholds_t;

  typedef struct packed {
    logic [31:0] data;
    logic last;
  } out_word_t;

  // kind is 0 ahead of timestamps, 1 ahead of data
  typedef struct packed {
    logic kind;
    logic [6:0] channel;
    logic [23:0] count;
  } header_t;

  ////////////////////
  // APB register offsets
  ////////////////////
  localparam logic [11:0] reg_ctrl_addr = 12'h000;
  localparam logic [11:0] reg_status_addr = 12'h004;
  localparam logic [11:0] reg_thresh_base = 12'h010;

endpackage

//--- rtl/sparse_sample_buffer.sv
/*
 * Top level of the sparse sample buffer.
 * in_stream is {valid, beats[channels-1:0]} with valid in the top bit.
 * Capture is steered over APB, and readout runs after a stop.
 */
`timescale 1ns/1ns

module sparse_sample_buffer #(
  parameter int channels = 4,
  parameter int tstamp_depth = 16,
  parameter int data_depth = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic psel,
  input  logic penable,
  input  logic pwrite,
  input  logic [11:0] paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic pready,
  output logic pslverr,
  input  logic [channels*$bits(sparse_buffer_pkg::beat_t):0] in_stream,
  output logic out_valid,
  output sparse_buffer_pkg::out_word_t out_word,
  input  logic out_ready
);

  typedef struct packed {
    logic valid;
    sparse_buffer_pkg::beat_t [channels-1:0] beats;
  } stream_in_t;

  localparam int tfill_width = $clog2(tstamp_depth + 1);
  localparam int dfill_width = $clog2(data_depth + 1);

  stream_in_t in_s;
  logic start;
  logic stop;
  logic capturing;
  logic readout_busy;
  sparse_buffer_pkg::thresholds_t [channels-1:0] thresholds;
  logic [channels-1:0] full_flags;
  logic [channels-1:0] data_wr;
  logic [channels-1:0] tstamp_wr;
  logic [channels-1:0] data_rd;
  logic [channels-1:0] tstamp_rd;
  logic [channels-1:0] data_empty;
  logic [channels-1:0] tstamp_empty;
  sparse_buffer_pkg::beat_t [channels-1:0] data_beat;
  sparse_buffer_pkg::beat_t [channels-1:0] data_data;
  sparse_buffer_pkg::tstamp_t [channels-1:0] tstamp;
  sparse_buffer_pkg::tstamp_t [channels-1:0] tstamp_data;
  logic [channels-1:0][tfill_width-1:0] tstamp_fill;
  logic [channels-1:0][dfill_width-1:0] data_fill;

  assign in_s = in_stream;

  // capture runs from the cycle after start until stop
  always_ff @(posedge clk) begin
    if (reset) capturing <= 1'b0;
    else if (start) capturing <= 1'b1;
    else if (stop) capturing <= 1'b0;
  end

  buffer_config_regs #(.channels(channels)) i_buffer_config_regs (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .thresholds, .start, .stop,
    .capturing, .readout_busy, .full_flags
  );

  for (genvar c = 0; c < channels; c++) begin : g_channel
    sample_discriminator #(
      .tstamp_depth(tstamp_depth),
      .data_depth(data_depth)
    ) i_sample_discriminator (
      .clk, .reset, .start, .capturing,
      .in_valid(in_s.valid), .in_beat(in_s.beats[c]), .thresholds(thresholds[c]),
      .data_fill(data_fill[c]), .tstamp_fill(tstamp_fill[c]),
      .data_wr(data_wr[c]), .data_beat(data_beat[c]),
      .tstamp_wr(tstamp_wr[c]), .tstamp(tstamp[c]), .full(full_flags[c])
    );

    sample_fifo #(
      .payload_t(sparse_buffer_pkg::tstamp_t),
      .depth(tstamp_depth)
    ) i_tstamp_fifo (
      .clk, .reset, .clear(start), .wr(tstamp_wr[c]), .wr_data(tstamp[c]),
      .rd(tstamp_rd[c]), .rd_data(tstamp_data[c]), .fill(tstamp_fill[c]),
      .empty(tstamp_empty[c])
    );

    sample_fifo #(
      .payload_t(sparse_buffer_pkg::beat_t),
      .depth(data_depth)
    ) i_data_fifo (
      .clk, .reset, .clear(start), .wr(data_wr[c]), .wr_data(data_beat[c]),
      .rd(data_rd[c]), .rd_data(data_data[c]), .fill(data_fill[c]),
      .empty(data_empty[c])
    );
  end

  buffer_readout #(
    .channels(channels),
    .tstamp_depth(tstamp_depth),
    .data_depth(data_depth)
  ) i_buffer_readout (
    .clk, .reset, .stop, .tstamp_data, .tstamp_fill, .tstamp_empty,
    .data_data, .data_fill, .data_empty, .tstamp_rd, .data_rd,
    .out_valid, .out_word, .out_ready, .busy(readout_busy)
  );

  // the pipeline drains before the first header goes out
  a_readout_follows_stop: assert property (@(posedge clk) disable iff (reset)
    stop |-> ##2 readout_busy);

endmodule

//--- testbench/sparse_buffer_model.svh
/*
 * Reference model of the sparse sample buffer, included by the testbench.
 * channel_words runs one channel's recorded beats through the keep rule
 * and returns that channel's share of the output stream with last clear.
 */

typedef sparse_buffer_pkg::beat_t beat_q_t[$];
typedef sparse_buffer_pkg::out_word_t word_q_t[$];

// true when any sample of the beat lies above the level
function automatic logic any_above(input sparse_buffer_pkg::beat_t beat,
    input logic [sparse_buffer_pkg::sample_width-1:0] level);
  logic hit;
  hit = 1'b0;
  for (int s = 0; s < sparse_buffer_pkg::parallel_samples; s++) begin
    if (beat[s] > level) hit = 1'b1;
  end
  return hit;
endfunction

function automatic word_q_t channel_words(input int ch, input beat_q_t beats,
    input sparse_buffer_pkg::thresholds_t th, input int tdepth, input int ddepth,
    output logic full);
  word_q_t words;
  beat_q_t stored;
  sparse_buffer_pkg::tstamp_t stamps[$];
  sparse_buffer_pkg::tstamp_t ts;
  sparse_buffer_pkg::header_t hdr;
  sparse_buffer_pkg::out_word_t w;
  logic prev_kept;
  logic kept;
  logic run_start;
  prev_kept = 1'b0;
  full = 1'b0;
  foreach (beats[i]) begin
    kept = any_above(beats[i], th.high) || (prev_kept && any_above(beats[i], th.low));
    run_start = kept && !prev_kept;
    if (kept && !full) begin
      // a new run needs a timestamp slot as well as a data slot
      if (stored.size() < ddepth && (!run_start || stamps.size() < tdepth)) begin
        if (run_start) begin
          ts.beat_timer = 16'(i);
          ts.data_index = 16'(stored.size());
          stamps.push_back(ts);
        end
        stored.push_back(beats[i]);
      end else begin
        full = 1'b1;
      end
    end
    prev_kept = kept;
  end

  // timestamp header, timestamps, data header, data
  w.last = 1'b0;
  hdr = '0;
  hdr.channel = 7'(ch);
  hdr.count = 24'(stamps.size());
  w.data = hdr;
  words.push_back(w);
  foreach (stamps[k]) begin
    w.data = stamps[k];
    words.push_back(w);
  end
  hdr.kind = 1'b1;
  hdr.count = 24'(stored.size());
  w.data = hdr;
  words.push_back(w);
  foreach (stored[k]) begin
    w.data = stored[k];
    words.push_back(w);
  end
  return words;
endfunction

//--- testbench/sparse_sample_buffer_tb.sv
/*
 * Testbench for the sparse sample buffer.
 * Drives random beats and APB commands, collects the output stream under
 * random back-pressure and compares it word by word with the model.
 */
`timescale 1ns/1ns

module sparse_sample_buffer_tb;

  localparam int channels = 4;
  localparam int tstamp_depth = 16;
  localparam int data_depth = 64;
  localparam int wait_limit = 20000;

  `include "sparse_buffer_model.svh"

  logic clk;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic in_valid;
  sparse_buffer_pkg::beat_t [channels-1:0] in_beats;
  logic out_valid;
  sparse_buffer_pkg::out_word_t out_word;
  logic out_ready;

  beat_q_t recorded [channels];
  sparse_buffer_pkg::thresholds_t thresh [channels];
  word_q_t expected;
  logic [channels-1:0] exp_full;
  logic seen_last;
  int ready_pct;
  int errors;
  int pass_count;
  int fail_count;

  tb_clock i_tb_clock (.clk, .reset);

  sparse_sample_buffer #(
    .channels(channels),
    .tstamp_depth(tstamp_depth),
    .data_depth(data_depth)
  ) i_sparse_sample_buffer (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .in_stream({in_valid, in_beats}),
    .out_valid, .out_word, .out_ready
  );

  task automatic check_value(input string what, input logic [63:0] got,
      input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run(input bit timed_out);
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (timed_out || fail_count != 0 || errors != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    finish_run(1'b1);
  endtask

  ////////////////////
  // output side
  ////////////////////
  always @(posedge clk) begin
    #1;
    out_ready = ($urandom_range(99) < ready_pct);
  end

  // every transferred word is checked against the head of the model queue
  always @(posedge clk) begin
    sparse_buffer_pkg::out_word_t exp_word;
    if (!reset && out_valid && out_ready) begin
      if (expected.size() == 0) begin
        errors++;
        $display("extra output word %h at %0t ns", out_word, $time);
      end else begin
        exp_word = expected.pop_front();
        check_value("output word", 64'(out_word), 64'(exp_word));
      end
      if (out_word.last) seen_last = 1'b1;
    end
  end

  ////////////////////
  // APB and stimulus
  ////////////////////
  task automatic apb_transfer(input logic write, input logic [11:0] addr,
      input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
    int n;
    @(posedge clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    n = 0;
    @(posedge clk);
    while (!pready && n < wait_limit) begin
      @(posedge clk);
      n++;
    end
    if (!pready) begin
      report_timeout("pready");
    end else begin
      // the access completes on its first edge
      check_value("apb wait cycles", 64'(n), 64'(0));
      rdata = prdata;
      err = pslverr;
      #1;
      psel = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic set_threshold(input int ch, input int high, input int low);
    logic [31:0] rdata;
    logic err;
    thresh[ch].high = 16'(high);
    thresh[ch].low = 16'(low);
    apb_transfer(1'b1, sparse_buffer_pkg::reg_thresh_base + 12'(4 * ch), thresh[ch],
        rdata, err);
  endtask

  // keeps drawing until n valid beats went in; idle cycles carry junk
  task automatic drive_beats(input int n, input int lo, input int hi, input int gap_pct);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      #1;
      in_valid = ($urandom_range(99) >= gap_pct);
      for (int c = 0; c < channels; c++) begin
        for (int s = 0; s < sparse_buffer_pkg::parallel_samples; s++) begin
          in_beats[c][s] = 16'($urandom_range(hi, lo));
        end
        if (in_valid) recorded[c].push_back(in_beats[c]);
      end
      if (in_valid) sent++;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic build_expected();
    word_q_t words;
    sparse_buffer_pkg::out_word_t w;
    logic full;
    expected.delete();
    for (int c = 0; c < channels; c++) begin
      words = channel_words(c, recorded[c], thresh[c], tstamp_depth, data_depth, full);
      exp_full[c] = full;
      foreach (words[i]) expected.push_back(words[i]);
    end
    w = expected.pop_back();
    w.last = 1'b1;
    expected.push_back(w);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      pass_count++;
      $display("test %s: pass", name);
    end else begin
      fail_count++;
      $display("test %s: fail with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic run_capture(input string name, input int n, input int lo, input int hi,
      input int gap_pct, input int ready);
    logic [31:0] rdata;
    logic err;
    int errs_before;
    int cycles;
    errs_before = errors;
    for (int c = 0; c < channels; c++) recorded[c].delete();
    ready_pct = ready;
    seen_last = 1'b0;
    apb_transfer(1'b1, sparse_buffer_pkg::reg_ctrl_addr, 32'h1, rdata, err);
    @(posedge clk);
    drive_beats(n, lo, hi, gap_pct);
    build_expected();
    apb_transfer(1'b1, sparse_buffer_pkg::reg_ctrl_addr, 32'h2, rdata, err);
    cycles = 0;
    while (!seen_last && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!seen_last) begin
      report_timeout("the last output word");
    end else begin
      repeat (4) @(posedge clk);
      check_value("words never sent", 64'(expected.size()), 64'(0));
      // capture and readout idle, full flags from the model
      apb_transfer(1'b0, sparse_buffer_pkg::reg_status_addr, 32'h0, rdata, err);
      check_value("status", 64'(rdata), 64'({exp_full, 8'h00}));
      report_test(name, errs_before);
    end
  endtask

  task automatic check_registers();
    logic [31:0] rdata;
    logic err;
    int errs_before;
    errs_before = errors;
    apb_transfer(1'b0, 12'h0fc, 32'h0, rdata, err);
    check_value("unmapped pslverr", 64'(err), 64'(1));
    apb_transfer(1'b1, sparse_buffer_pkg::reg_thresh_base + 12'h8, 32'h1234_0567, rdata, err);
    check_value("threshold write pslverr", 64'(err), 64'(0));
    apb_transfer(1'b0, sparse_buffer_pkg::reg_thresh_base + 12'h8, 32'h0, rdata, err);
    check_value("threshold readback", 64'(rdata), 64'(32'h1234_0567));
    report_test("register access", errs_before);
  endtask

  ////////////////////
  // test sequence
  ////////////////////
  initial begin
    int n;
    void'($urandom(32'h2e567205));
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    in_valid = 1'b0;
    in_beats = '0;
    out_ready = 1'b0;
    ready_pct = 100;
    seen_last = 1'b0;
    exp_full = '0;
    errors = 0;
    pass_count = 0;
    fail_count = 0;
    n = 0;
    while ((reset !== 1'b0) && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (reset !== 1'b0) begin
      report_timeout("reset release");
    end else begin
      for (int c = 0; c < channels; c++) set_threshold(c, 1000, 500);
      run_capture("all above high", 40, 2000, 65535, 0, 100);

      // strong hysteresis on 0 and 2, weak on 1 and 3
      set_threshold(0, 30000, 10000);
      set_threshold(1, 30000, 28000);
      set_threshold(2, 40000, 20000);
      set_threshold(3, 25000, 24000);
      run_capture("hysteresis with gaps", 50, 0, 50000, 30, 100);

      for (int c = 0; c < channels; c++) set_threshold(c, 60000, 50000);
      run_capture("all below low", 30, 0, 40000, 0, 100);

      for (int c = 0; c < channels; c++) set_threshold(c, 20000, 5000);
      run_capture("data fifo full", 200, 0, 65535, 10, 100);

      set_threshold(0, 30000, 10000);
      set_threshold(1, 30000, 28000);
      set_threshold(2, 40000, 20000);
      set_threshold(3, 25000, 24000);
      run_capture("output stalls", 60, 0, 50000, 20, 30);

      check_registers();
      finish_run(1'b0);
    end
  end

endmodule

//--- testbench/tb_clock.sv
/*
 * Clock and reset source for the sparse sample buffer testbench.
 * Makes a 4 ns clock and holds reset high for the first four cycles.
 */
`timescale 1ns/1ns

module tb_clock #(
  parameter int period = 4,
  parameter int reset_cycles = 4
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // release 1 ns after an edge, like the other inputs
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule
